//--- sim/alu_fpga_properties.sv
// concurrent assertions on the ALU board top and their bind into alu_fpga
`timescale 1ns/1ps

module alu_fpga_properties (
  input logic                 CLOCK_50,
  input logic                 arst_n,
  input board_pkg::sw_t       SW,
  input board_pkg::ledg_t     LEDG,
  input cpu_types_pkg::word_t b,
  input cpu_types_pkg::word_t out
);

  // ==========================================================================
  // led and flag rules
  // ==========================================================================

  upper_ledg_zero: assert property (@(posedge CLOCK_50) LEDG[7:3] == 5'b0)
    else $error("upper green leds are not zero");

  // zero flag as it reaches the green leds
  zero_flag_shown: assert property (@(posedge CLOCK_50) LEDG[0] == (out == '0))
    else $error("zero flag led disagrees with the ALU result");

  // ==========================================================================
  // operand B register
  // ==========================================================================

  // SW[17] seen high at an edge means that edge did not load B
  b_holds: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    SW[17] |=> $stable(b))
    else $error("operand B changed while SW[17] was high");

  b_clear_in_reset: assert property (@(posedge CLOCK_50) !arst_n |-> b == '0)
    else $error("operand B is not zero during reset");

endmodule

bind alu_fpga alu_fpga_properties i_props (
  .CLOCK_50 (CLOCK_50),
  .arst_n   (arst_n),
  .SW       (SW),
  .LEDG     (LEDG),
  .b        (b),
  .out      (out)
);

//--- sim/alu_fpga_tb.sv
// alu_fpga_tb: clock, reset, directed table, xorshift random steps, reference model, checks
`timescale 1ns/1ps

module alu_fpga_tb;

  import cpu_types_pkg::*;
  import board_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int N_DIRECTED  = 20;
  localparam int N_RANDOM    = 200;
  localparam int CYCLE_LIMIT = 2 * (N_DIRECTED + N_RANDOM) + 50;

  // active-low glyphs for 0..f, bit 0 is segment a
  localparam seg_t GLYPHS [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h10, 7'h08, 7'h03, 7'h27, 7'h21, 7'h06, 7'h0e};

  logic  CLOCK_50;
  logic  arst_n;
  key_t  KEY;
  sw_t   SW;
  ledr_t LEDR;
  ledg_t LEDG;
  seg_t  HEX0;
  seg_t  HEX1;
  seg_t  HEX4;
  seg_t  HEX5;
  seg_t  HEX6;
  seg_t  HEX7;

  sw_t   tab_sw   [N_DIRECTED];
  key_t  tab_key  [N_DIRECTED];
  ledr_t tab_ledr [N_DIRECTED];
  ledg_t tab_ledg [N_DIRECTED];
  int    tab_count;
  int    error_count;
  int    step_idx;
  int    cycle_count;
  logic [31:0] rng_state;
  word_t b_model;  // operand B as the board should hold it

  alu_fpga i_dut (
    .CLOCK_50 (CLOCK_50),
    .arst_n   (arst_n),
    .KEY      (KEY),
    .SW       (SW),
    .LEDR     (LEDR),
    .LEDG     (LEDG),
    .HEX0     (HEX0),
    .HEX1     (HEX1),
    .HEX4     (HEX4),
    .HEX5     (HEX5),
    .HEX6     (HEX6),
    .HEX7     (HEX7)
  );

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
  end

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t sext_sw(input sw_t s);
    return {{15{s[16]}}, s[16:0]};
  endfunction

  function automatic key_t keys_for_op(input logic [3:0] code);
    return key_t'(~code);  // pressed button reads 0
  endfunction

  function automatic word_t model_result(input word_t a, input word_t b, input logic [3:0] code);
    word_t r;
    case (code)
      ALU_SLL:  r = b << a[4:0];
      ALU_SRL:  r = b >> a[4:0];
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_NOR:  r = ~(a | b);
      ALU_SLT:  r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
      ALU_SLTU: r = word_t'(a < b);
      default:  r = '0;
    endcase
    return r;
  endfunction

  // 33-bit signed arithmetic, overflow when the two top bits disagree
  function automatic logic model_overflow(input word_t a, input word_t b, input logic [3:0] code);
    logic [32:0] wide;
    wide = '0;
    if (code == ALU_ADD)
      wide = {a[31], a} + {b[31], b};
    else if (code == ALU_SUB)
      wide = {a[31], a} - {b[31], b};
    return wide[32] != wide[31];
  endfunction

  // ==========================================================================
  // stimulus and checks
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s: expected %h, actual %h (step %0d)", name, expected, actual,
               step_idx);
      error_count++;
    end
  endtask

  task automatic check_board(input ledr_t exp_ledr, input ledg_t exp_ledg, input word_t a_val);
    check_value("LEDR", exp_ledr, LEDR);
    check_value("LEDG", exp_ledg, LEDG);
    check_value("HEX0", GLYPHS[exp_ledr[3:0]], HEX0);
    check_value("HEX1", GLYPHS[exp_ledr[7:4]], HEX1);
    check_value("HEX4", GLYPHS[b_model[3:0]], HEX4);
    check_value("HEX5", GLYPHS[b_model[7:4]], HEX5);
    check_value("HEX6", GLYPHS[a_val[3:0]], HEX6);
    check_value("HEX7", GLYPHS[a_val[7:4]], HEX7);
  endtask

  task automatic apply_step(input sw_t sw, input key_t key);
    @(posedge CLOCK_50);
    #(DRIVE_DELAY);
    SW  = sw;
    KEY = key;
    #(CLK_PERIOD - DRIVE_DELAY - 2);  // 2 ns before the next edge
  endtask

  // B takes the switches at the edge that ends this step
  task automatic update_b(input sw_t sw);
    if (!sw[17])
      b_model = sext_sw(sw);
  endtask

  task automatic add_step(input sw_t sw, input key_t key, input ledr_t ledr, input ledg_t ledg);
    if (tab_count < N_DIRECTED)
    begin
      tab_sw[tab_count]   = sw;
      tab_key[tab_count]  = key;
      tab_ledr[tab_count] = ledr;
      tab_ledg[tab_count] = ledg;
    end
    tab_count++;
  endtask

  // SW[17] low loads B at the end of the step, ledg is {ovf, neg, zero}
  task automatic fill_table();
    add_step(18'h20012, keys_for_op(ALU_ADD),  18'h00012, 8'h00);  // B still zero
    add_step(18'h00005, keys_for_op(ALU_ADD),  18'h00005, 8'h00);  // B <= 5
    add_step(18'h20005, keys_for_op(ALU_SUB),  18'h00000, 8'h01);
    add_step(18'h20003, keys_for_op(ALU_SUB),  18'h3fffe, 8'h02);
    add_step(18'h3fff0, keys_for_op(ALU_ADD),  18'h3fff5, 8'h02);
    add_step(18'h1fffc, keys_for_op(ALU_ADD),  18'h00001, 8'h00);  // B <= -4
    add_step(18'h20007, keys_for_op(ALU_ADD),  18'h00003, 8'h00);
    add_step(18'h20007, keys_for_op(ALU_SLT),  18'h00000, 8'h01);
    add_step(18'h20007, keys_for_op(ALU_SLTU), 18'h00001, 8'h00);
    add_step(18'h20002, keys_for_op(ALU_SLL),  18'h3fff0, 8'h02);
    add_step(18'h20004, keys_for_op(ALU_SRL),  18'h3ffff, 8'h00);
    add_step(18'h000c3, keys_for_op(ALU_AND),  18'h000c0, 8'h00);  // B <= 0xc3
    add_step(18'h200a5, keys_for_op(ALU_AND),  18'h00081, 8'h00);
    add_step(18'h200a5, keys_for_op(ALU_OR),   18'h000e7, 8'h00);
    add_step(18'h200a5, keys_for_op(ALU_XOR),  18'h00066, 8'h00);
    add_step(18'h200a5, keys_for_op(ALU_NOR),  18'h3ff18, 8'h02);
    add_step(18'h200a5, keys_for_op(4'd10),    18'h00000, 8'h01);  // undefined
    add_step(18'h200a5, keys_for_op(4'd15),    18'h00000, 8'h01);
    add_step(18'h2009b, keys_for_op(ALU_ADD),  18'h0015e, 8'h00);
    add_step(18'h200d4, keys_for_op(ALU_XOR),  18'h00017, 8'h00);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial
  begin
    sw_t   rsw;
    key_t  rkey;
    word_t ra;
    word_t rres;
    ledg_t rledg;
    arst_n      = 1'b1;
    SW          = 18'h20000;  // hold B
    KEY         = 4'hf;
    error_count = 0;
    step_idx    = 0;
    tab_count   = 0;
    b_model     = '0;
    rng_state   = 32'hd776;
    fill_table();
    if (tab_count != N_DIRECTED)
    begin
      $display("stimulus table holds %0d steps instead of %0d", tab_count, N_DIRECTED);
      error_count++;
    end
    #1;
    arst_n = 1'b0;
    repeat (4) @(posedge CLOCK_50);
    #(DRIVE_DELAY);
    arst_n = 1'b1;

    for (int i = 0; i < N_DIRECTED; i++)
    begin
      step_idx = i;
      apply_step(tab_sw[i], tab_key[i]);
      check_board(tab_ledr[i], tab_ledg[i], sext_sw(tab_sw[i]));
      update_b(tab_sw[i]);
    end

    for (int i = 0; i < N_RANDOM; i++)
    begin
      rng_state = xorshift32(rng_state);
      rsw       = rng_state[17:0];
      rkey      = rng_state[21:18];
      ra        = sext_sw(rsw);
      rres      = model_result(ra, b_model, ~rkey);
      rledg     = {5'b0, model_overflow(ra, b_model, ~rkey), rres[31], (rres == '0)};
      step_idx  = N_DIRECTED + i;
      apply_step(rsw, rkey);
      check_board(rres[17:0], rledg, ra);
      update_b(rsw);
    end

    $display("errors: %0d in %0d directed and %0d random steps", error_count, N_DIRECTED,
             N_RANDOM);
    if (error_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // watchdog
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge CLOCK_50);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles, %0d errors so far", CYCLE_LIMIT,
             error_count);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- src/alu.sv
// alu: combinational 32-bit ALU with zero, negative and overflow flags
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::word_t  a,
  input  cpu_types_pkg::word_t  b,
  input  cpu_types_pkg::aluop_t op,
  output cpu_types_pkg::word_t  out,
  output logic                  zero_flag,
  output logic                  negative_flag,
  output logic                  overflow_flag
);

  import cpu_types_pkg::*;

  shamt_t shamt;
  word_t  sum;
  word_t  diff;
  logic   add_ovf;
  logic   sub_ovf;

  // ==========================================================================
  // arithmetic
  // ==========================================================================

  assign shamt = a[4:0];  // shifts take the amount from a
  assign sum   = a + b;
  assign diff  = a - b;

  // same operand signs but result sign differs
  assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);

  // operand signs differ and the result takes the sign of b
  assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

  // ==========================================================================
  // result select
  // ==========================================================================

  always_comb
  begin
    out = '0;
    case (op)
      ALU_SLL:
      begin
        out = b << shamt;
      end
      ALU_SRL:
      begin
        out = b >> shamt;  // logical
      end
      ALU_ADD:
      begin
        out = sum;
      end
      ALU_SUB:
      begin
        out = diff;
      end
      ALU_AND:
      begin
        out = a & b;
      end
      ALU_OR:
      begin
        out = a | b;
      end
      ALU_XOR:
      begin
        out = a ^ b;
      end
      ALU_NOR:
      begin
        out = ~(a | b);
      end
      ALU_SLT:
      begin
        out = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      end
      ALU_SLTU:
      begin
        out = (a < b) ? word_t'(1) : '0;
      end
      default:
      begin
        out = '0;  // undefined codes
      end
    endcase
  end

  // ==========================================================================
  // flags
  // ==========================================================================

  assign zero_flag     = (out == '0);
  assign negative_flag = out[WORD_W-1];

  always_comb
  begin
    case (op)
      ALU_ADD:
      begin
        overflow_flag = add_ovf;
      end
      ALU_SUB:
      begin
        overflow_flag = sub_ovf;
      end
      default:
      begin
        overflow_flag = 1'b0;  // only arithmetic can overflow
      end
    endcase
  end

endmodule

//--- src/alu_fpga.sv
// alu_fpga: DE2 board top for the ALU with operand B register, LEDs and hex display
`timescale 1ns/1ps

module alu_fpga (
  input  logic             CLOCK_50,
  input  logic             arst_n,
  input  board_pkg::key_t  KEY,
  input  board_pkg::sw_t   SW,
  output board_pkg::ledr_t LEDR,
  output board_pkg::ledg_t LEDG,
  output board_pkg::seg_t  HEX0,
  output board_pkg::seg_t  HEX1,
  output board_pkg::seg_t  HEX4,
  output board_pkg::seg_t  HEX5,
  output board_pkg::seg_t  HEX6,
  output board_pkg::seg_t  HEX7
);

  import cpu_types_pkg::*;
  import board_pkg::*;

  localparam int HOLD_SW = SW_W - 1;  // SW[17] high freezes B
  localparam int SIGN_SW = SW_W - 2;  // SW[16] is the operand sign

  word_t  a;
  word_t  b;
  aluop_t op;
  word_t  out;
  logic   zero_flag;
  logic   negative_flag;
  logic   overflow_flag;
  logic   load_b;

  // ==========================================================================
  // operands and operation
  // ==========================================================================

  // 17-bit switch value, sign extended
  assign a = {{(WORD_W-16){SW[SIGN_SW]}}, SW[15:0]};

  assign load_b = ~SW[HOLD_SW];

  // B takes the same sign-extended switch value, held while SW[17] is up
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      b <= '0;
    end
    else if (load_b)
    begin
      b <= a;
    end
  end

  // buttons are active low, pressed button sets its op bit
  assign op = aluop_t'(~KEY);

  alu i_alu (
    .a             (a),
    .b             (b),
    .op            (op),
    .out           (out),
    .zero_flag     (zero_flag),
    .negative_flag (negative_flag),
    .overflow_flag (overflow_flag)
  );

  // ==========================================================================
  // leds
  // ==========================================================================

  assign LEDR = out[LEDR_W-1:0];

  // upper green leds unused
  assign LEDG = {{(LEDG_W-3){1'b0}}, overflow_flag, negative_flag, zero_flag};

  // ==========================================================================
  // hex display
  // ==========================================================================

  // result low byte
  hex_digit_decoder i_hex0 (
    .digit (out[3:0]),
    .seg   (HEX0)
  );

  hex_digit_decoder i_hex1 (
    .digit (out[7:4]),
    .seg   (HEX1)
  );

  // operand B low byte
  hex_digit_decoder i_hex4 (
    .digit (b[3:0]),
    .seg   (HEX4)
  );

  hex_digit_decoder i_hex5 (
    .digit (b[7:4]),
    .seg   (HEX5)
  );

  // operand A low byte
  hex_digit_decoder i_hex6 (
    .digit (a[3:0]),
    .seg   (HEX6)
  );

  hex_digit_decoder i_hex7 (
    .digit (a[7:4]),
    .seg   (HEX7)
  );

endmodule

//--- src/board_pkg.sv
// board I/O widths, switch/key/LED vector types, seven-segment and nibble types
package board_pkg;

  // ==========================================================================
  // DE2 board I/O
  // ==========================================================================

  localparam int SW_W   = 18;  // slide switches
  localparam int KEY_W  = 4;   // push buttons, active low
  localparam int LEDR_W = 18;  // red leds
  localparam int LEDG_W = 8;   // green leds

  typedef logic [SW_W-1:0]   sw_t;
  typedef logic [KEY_W-1:0]  key_t;
  typedef logic [LEDR_W-1:0] ledr_t;
  typedef logic [LEDG_W-1:0] ledg_t;

  // segment pattern, active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  typedef logic [3:0] nibble_t;  // one hex digit

endpackage

//--- src/cpu_types_pkg.sv
// datapath width, word and shift amount types, ALU operation codes
package cpu_types_pkg;

  // ==========================================================================
  // datapath
  // ==========================================================================

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;  // one data word
  typedef logic [4:0]        shamt_t; // shift amount

  // ==========================================================================
  // alu operations
  // ==========================================================================

  // codes 10 to 15 are undefined and produce zero
  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,  // signed compare
    ALU_SLTU = 4'd9   // unsigned compare
  } aluop_t;

endpackage

//--- src/hex_digit_decoder.sv
// hex_digit_decoder: one hex nibble to an active-low seven-segment glyph
`timescale 1ns/1ps

module hex_digit_decoder (
  input  board_pkg::nibble_t digit,
  output board_pkg::seg_t    seg
);

  // segments gfedcba, a lit segment is 0
  always_comb
  begin
    unique case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;  // A
      4'hb: seg = 7'b0000011;  // lower case b
      4'hc: seg = 7'b0100111;  // lower case c
      4'hd: seg = 7'b0100001;  // lower case d
      4'he: seg = 7'b0000110;
      4'hf: seg = 7'b0001110;
    endcase
  end

endmodule

//--- vlog.f
src/cpu_types_pkg.sv
src/board_pkg.sv
src/alu.sv
src/hex_digit_decoder.sv
src/alu_fpga.sv
sim/alu_fpga_properties.sv
sim/alu_fpga_tb.sv
